/* pad_pkg.sv */
package pad_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    localparam int LINE_SIZE = 6;   // tile rows / cols
    localparam int ADDR_W    = 11;  // in-bank address
    localparam int NUM_BANKS = 3;   // columns rotate over these

    // bit positions inside edge_mask_t, mask reads {up, down, left, right}
    localparam int EDGE_UP    = 3;
    localparam int EDGE_DOWN  = 2;
    localparam int EDGE_LEFT  = 1;
    localparam int EDGE_RIGHT = 0;

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////

    typedef logic [LINE_SIZE-1:0] tile_dim_t;  // tile row or column count
    typedef logic [LINE_SIZE:0]   pos_t;       // position, padded index
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [1:0]           bank_t;      // 0..2
    typedef logic [3:0]           edge_mask_t;

    // padding type codes as seen on the request port
    typedef enum logic [3:0] {
        left_up        = 4'd0,
        up             = 4'd1,
        right_up       = 4'd2,
        left           = 4'd3,
        middle         = 4'd4,
        right          = 4'd5,
        left_down      = 4'd6,
        down           = 4'd7,
        right_down     = 4'd8,
        all_padding    = 4'd9,
        all_no_padding = 4'd10
    } pad_type_t;

endpackage

/* pad_request_decode.sv */
`timescale 1ns/1ps

module pad_request_decode
    import pad_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // request side
    input  logic       start_valid,
    output logic       start_ready,
    input  pad_type_t  pad_type,
    input  tile_dim_t  tile_rows,
    input  tile_dim_t  tile_cols,
    input  pos_t       row_position,
    input  pos_t       col_position,
    // job descriptor to the walker
    output logic       job_valid,
    input  logic       job_ready,
    output edge_mask_t edges,
    output pos_t       last_row,
    output pos_t       last_col,
    output pos_t       job_row_position,
    output pos_t       job_col_position
);

    edge_mask_t type_edges;
    logic       take;

    assign start_ready = !job_valid;  // one job in flight at most
    assign take        = start_valid && start_ready;

    //////////////////////////////////////////////////
    // type to edge mask
    //////////////////////////////////////////////////

    always_comb begin
        case (pad_type)
            left_up:     type_edges = 4'b1010;
            up:          type_edges = 4'b1000;
            right_up:    type_edges = 4'b1001;
            left:        type_edges = 4'b0010;
            right:       type_edges = 4'b0001;
            left_down:   type_edges = 4'b0110;
            down:        type_edges = 4'b0100;
            right_down:  type_edges = 4'b0101;
            all_padding: type_edges = 4'b1111;
            default:     type_edges = 4'b0000;  // middle, no padding, bad codes
        endcase
    end

    //////////////////////////////////////////////////
    // job register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            job_valid <= 1'b0;
        end else if (take) begin
            job_valid <= 1'b1;
        end else if (job_ready) begin
            job_valid <= 1'b0;   // walker is finished with it
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            edges            <= type_edges;
            last_row         <= pos_t'(tile_rows) + pos_t'(1);  // H-1
            last_col         <= pos_t'(tile_cols) + pos_t'(1);  // W-1
            job_row_position <= row_position;
            job_col_position <= col_position;
        end
    end

endmodule

/* pad_cell_walker.sv */
`timescale 1ns/1ps

module pad_cell_walker
    import pad_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       job_valid,
    output logic       job_ready,
    input  edge_mask_t edges,
    input  pos_t       last_row,
    input  pos_t       last_col,
    input  pos_t       job_row_position,
    input  pos_t       job_col_position,
    output logic       cell_valid,
    input  logic       cell_ready,
    output pos_t       cell_row,
    output pos_t       cell_col,
    output logic       cell_last,
    output logic       cell_empty
);

    localparam int PW     = $bits(pos_t);
    localparam int CELL_W = 2 * PW + 1;  // {found, row, col}

    logic              active;      // job taken and not yet released
    logic              wait_drain;  // last cell sits in the output stage
    pos_t              cur_row;
    pos_t              cur_col;
    logic [CELL_W-1:0] first_cell;
    logic [CELL_W-1:0] first_step;
    logic [CELL_W-1:0] next_cell;
    logic [CELL_W-1:0] next_step;

    // every row enabled on this column
    function automatic logic full_col(input pos_t c, input edge_mask_t e, input pos_t lc);
        return (e[EDGE_UP] && c == '0) || (e[EDGE_DOWN] && c == lc);
    endfunction

    // first enabled cell at column c or beyond
    function automatic logic [CELL_W-1:0] first_from(input pos_t c, input edge_mask_t e,
                                                     input pos_t lr, input pos_t lc);
        if (c > lc)
            return '0;
        else if (full_col(c, e, lc) || e[EDGE_LEFT])
            return {1'b1, pos_t'(0), c};
        else if (e[EDGE_RIGHT])
            return {1'b1, lr, c};
        else if (e[EDGE_DOWN])
            return {1'b1, pos_t'(0), lc};  // skip the empty middle columns
        else
            return '0;
    endfunction

    // enabled cell following (r, c) in column-major order
    function automatic logic [CELL_W-1:0] step(input pos_t r, input pos_t c, input edge_mask_t e,
                                               input pos_t lr, input pos_t lc);
        if (full_col(c, e, lc) && r < lr)
            return {1'b1, pos_t'(r + 1'b1), c};
        else if (!full_col(c, e, lc) && r == '0 && e[EDGE_RIGHT])
            return {1'b1, lr, c};              // top row done, jump to bottom row
        else if (c < lc)
            return first_from(pos_t'(c + 1'b1), e, lr, lc);
        else
            return '0;
    endfunction

    // looked up one cell ahead so the final one carries the last flag
    assign first_cell = first_from('0, edges, last_row, last_col);
    assign first_step = step(first_cell[2*PW-1:PW], first_cell[PW-1:0], edges, last_row, last_col);
    assign next_cell  = step(cur_row, cur_col, edges, last_row, last_col);
    assign next_step  = step(next_cell[2*PW-1:PW], next_cell[PW-1:0], edges, last_row, last_col);

    assign cell_row = job_row_position + cur_row;  // absolute row
    assign cell_col = job_col_position + cur_col;  // absolute column

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            wait_drain <= 1'b0;
            job_ready  <= 1'b0;
            cell_valid <= 1'b0;
            cell_last  <= 1'b0;
            cell_empty <= 1'b0;
            cur_row    <= '0;
            cur_col    <= '0;
        end else begin
            job_ready <= 1'b0;
            if (!active) begin
                if (job_valid) begin
                    active     <= 1'b1;
                    cell_valid <= 1'b1;
                    cur_row    <= first_cell[2*PW-1:PW];
                    cur_col    <= first_cell[PW-1:0];
                    cell_empty <= !first_cell[2*PW];  // no edges at all
                    cell_last  <= !first_cell[2*PW] || !first_step[2*PW];
                end
            end else if (job_ready) begin
                active <= 1'b0;
            end else if (cell_valid && cell_ready) begin
                if (cell_last) begin
                    cell_valid <= 1'b0;
                    wait_drain <= !cell_empty;
                    job_ready  <= cell_empty;   // empty token frees at once
                end else begin
                    cur_row   <= next_cell[2*PW-1:PW];
                    cur_col   <= next_cell[PW-1:0];
                    cell_last <= !next_step[2*PW];
                end
            end else if (wait_drain && cell_ready) begin
                wait_drain <= 1'b0;   // last address leaves this cycle
                job_ready  <= 1'b1;
            end
        end
    end

endmodule

/* pad_addr_result.sv */
`timescale 1ns/1ps

module pad_addr_result
    import pad_pkg::*;
#(
    parameter int MAX_TILE_SIZE = 34   // address stride of one bank column
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  cell_valid,
    output logic  cell_ready,
    input  pos_t  cell_row,
    input  pos_t  cell_col,
    input  logic  cell_last,
    input  logic  cell_empty,
    output logic  addr_valid,
    input  logic  addr_ready,
    output bank_t bank,
    output addr_t addr,
    output logic  done
);

    localparam int COL_RANGE = 2 ** $bits(pos_t);

    bank_t cell_bank;
    pos_t  cell_bcol;   // column index inside the bank
    addr_t cell_addr;
    logic  take;
    logic  out_last;

    //////////////////////////////////////////////////
    // column split, mod 3 and div 3
    //////////////////////////////////////////////////

    always_comb begin
        cell_bank = '0;
        cell_bcol = '0;
        for (int i = 0; i < COL_RANGE; i++) begin
            if (cell_col == pos_t'(i)) begin
                cell_bank = bank_t'(i % NUM_BANKS);
                cell_bcol = pos_t'(i / NUM_BANKS);
            end
        end
    end

    assign cell_addr = addr_t'(cell_row) + addr_t'(cell_bcol) * addr_t'(MAX_TILE_SIZE);

    //////////////////////////////////////////////////
    // output stage
    //////////////////////////////////////////////////

    assign cell_ready = !addr_valid || addr_ready;  // empty or draining
    assign take       = cell_valid && cell_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_valid <= 1'b0;
            out_last   <= 1'b0;
            done       <= 1'b0;
        end else begin
            // after the final address leaves, or right after an empty token
            done <= (addr_valid && addr_ready && out_last) || (take && cell_empty);
            if (take) begin
                addr_valid <= !cell_empty;
                out_last   <= cell_last && !cell_empty;
            end else if (addr_ready) begin
                addr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && !cell_empty) begin
            bank <= cell_bank;
            addr <= cell_addr;
        end
    end

endmodule

/* pad_addr_gen.sv */
`timescale 1ns/1ps

module pad_addr_gen
    import pad_pkg::*;
#(
    parameter int MAX_TILE_SIZE = 34
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      start_valid,
    output logic      start_ready,
    input  pad_type_t pad_type,
    input  tile_dim_t tile_rows,
    input  tile_dim_t tile_cols,
    input  pos_t      row_position,
    input  pos_t      col_position,
    output logic      addr_valid,
    input  logic      addr_ready,
    output bank_t     bank,
    output addr_t     addr,
    output logic      done
);

    // decode to walker
    logic       job_valid;
    logic       job_ready;
    edge_mask_t edges;
    pos_t       last_row;
    pos_t       last_col;
    pos_t       job_row_position;
    pos_t       job_col_position;

    // walker to result
    logic       cell_valid;
    logic       cell_ready;
    pos_t       cell_row;
    pos_t       cell_col;
    logic       cell_last;
    logic       cell_empty;

    pad_request_decode u_decode (
        .clk              (clk),
        .rst              (rst),
        .start_valid      (start_valid),
        .start_ready      (start_ready),
        .pad_type         (pad_type),
        .tile_rows        (tile_rows),
        .tile_cols        (tile_cols),
        .row_position     (row_position),
        .col_position     (col_position),
        .job_valid        (job_valid),
        .job_ready        (job_ready),
        .edges            (edges),
        .last_row         (last_row),
        .last_col         (last_col),
        .job_row_position (job_row_position),
        .job_col_position (job_col_position)
    );

    pad_cell_walker u_walker (
        .clk              (clk),
        .rst              (rst),
        .job_valid        (job_valid),
        .job_ready        (job_ready),
        .edges            (edges),
        .last_row         (last_row),
        .last_col         (last_col),
        .job_row_position (job_row_position),
        .job_col_position (job_col_position),
        .cell_valid       (cell_valid),
        .cell_ready       (cell_ready),
        .cell_row         (cell_row),
        .cell_col         (cell_col),
        .cell_last        (cell_last),
        .cell_empty       (cell_empty)
    );

    pad_addr_result #(
        .MAX_TILE_SIZE (MAX_TILE_SIZE)
    ) u_result (
        .clk        (clk),
        .rst        (rst),
        .cell_valid (cell_valid),
        .cell_ready (cell_ready),
        .cell_row   (cell_row),
        .cell_col   (cell_col),
        .cell_last  (cell_last),
        .cell_empty (cell_empty),
        .addr_valid (addr_valid),
        .addr_ready (addr_ready),
        .bank       (bank),
        .addr       (addr),
        .done       (done)
    );

endmodule

/* pad_addr_gen_chk.sv */
`timescale 1ns/1ps

module pad_addr_gen_chk
    import pad_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  start_ready,
    input logic  addr_valid,
    input logic  addr_ready,
    input bank_t bank,
    input addr_t addr,
    input logic  done
);

    int assert_errors = 0;  // failed assertions so far

    // only three banks exist
    bank_legal: assert property (@(posedge clk) disable iff (rst)
        addr_valid |-> bank != 2'd3)
    else begin
        $error("bank number 3 on the output");
        assert_errors = assert_errors + 1;
    end

    // stalled output holds still
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        addr_valid && !addr_ready |=> addr_valid && $stable(bank) && $stable(addr))
    else begin
        $error("output changed while stalled");
        assert_errors = assert_errors + 1;
    end

    done_alone: assert property (@(posedge clk) disable iff (rst)
        !(done && addr_valid))
    else begin
        $error("done together with addr_valid");
        assert_errors = assert_errors + 1;
    end

    // no new request while a job streams out
    busy_blocks: assert property (@(posedge clk) disable iff (rst)
        addr_valid |-> !start_ready)
    else begin
        $error("start_ready high while addresses stream out");
        assert_errors = assert_errors + 1;
    end

endmodule

bind pad_addr_gen pad_addr_gen_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .start_ready (start_ready),
    .addr_valid  (addr_valid),
    .addr_ready  (addr_ready),
    .bank        (bank),
    .addr        (addr),
    .done        (done)
);

/* tb_pad_addr_gen.sv */
`timescale 1ns/1ps

module tb_pad_addr_gen
    import pad_pkg::*;
();

    localparam int MAX_TILE_SIZE = 34;
    localparam int TIMEOUT       = 100;  // idle cycles per wait

    logic      clk = 1'b0;
    logic      rst;
    logic      start_valid;
    logic      start_ready;
    pad_type_t pad_type;
    tile_dim_t tile_rows;
    tile_dim_t tile_cols;
    pos_t      row_position;
    pos_t      col_position;
    logic      addr_valid;
    logic      addr_ready;
    bank_t     bank;
    addr_t     addr;
    logic      done;

    int          error_count = 0;
    bit          aborted = 1'b0;
    logic [31:0] lfsr = 32'he90;
    int          exp_bank[$];
    int          exp_addr[$];

    pad_addr_gen #(
        .MAX_TILE_SIZE (MAX_TILE_SIZE)
    ) u_pad_addr_gen (
        .clk          (clk),
        .rst          (rst),
        .start_valid  (start_valid),
        .start_ready  (start_ready),
        .pad_type     (pad_type),
        .tile_rows    (tile_rows),
        .tile_cols    (tile_cols),
        .row_position (row_position),
        .col_position (col_position),
        .addr_valid   (addr_valid),
        .addr_ready   (addr_ready),
        .bank         (bank),
        .addr         (addr),
        .done         (done)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // random numbers
    //////////////////////////////////////////////////

    function automatic logic lfsr_step();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb)
            lfsr = lfsr ^ 32'hd000_0001;  // taps 32 31 29 1
        return lsb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | int'(lfsr_step());
        return v;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + rand_bits(8) % (hi - lo + 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////
    // reference model in column-major order
    //////////////////////////////////////////////////

    task automatic build_expected(input int pt, input int rows, input int cols,
                                  input int rp, input int cp);
        bit e_up;
        bit e_down;
        bit e_left;
        bit e_right;
        int acol;
        int arow;
        case (pt)
            0:       {e_up, e_down, e_left, e_right} = 4'b1010;  // left_up
            1:       {e_up, e_down, e_left, e_right} = 4'b1000;
            2:       {e_up, e_down, e_left, e_right} = 4'b1001;  // right_up
            3:       {e_up, e_down, e_left, e_right} = 4'b0010;
            5:       {e_up, e_down, e_left, e_right} = 4'b0001;
            6:       {e_up, e_down, e_left, e_right} = 4'b0110;  // left_down
            7:       {e_up, e_down, e_left, e_right} = 4'b0100;
            8:       {e_up, e_down, e_left, e_right} = 4'b0101;
            9:       {e_up, e_down, e_left, e_right} = 4'b1111;
            default: {e_up, e_down, e_left, e_right} = 4'b0000;  // middle, no padding
        endcase
        for (int c = 0; c < cols + 2; c++) begin
            for (int r = 0; r < rows + 2; r++) begin
                if ((e_up && c == 0) || (e_down && c == cols + 1) ||
                    (e_left && r == 0) || (e_right && r == rows + 1)) begin
                    acol = cp + c;
                    arow = rp + r;
                    exp_bank.push_back(acol % 3);
                    exp_addr.push_back(arow + (acol / 3) * MAX_TILE_SIZE);
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // one request from start to done
    //////////////////////////////////////////////////

    task automatic run_request(input int pt, input int rows, input int cols,
                               input int rp, input int cp, input bit stall);
        int cycles;
        int idle;
        int n_seen;
        int last_xfer;
        bit seen_done;
        exp_bank.delete();
        exp_addr.delete();
        build_expected(pt, rows, cols, rp, cp);
        start_valid  <= 1'b1;
        pad_type     <= pad_type_t'(pt);
        tile_rows    <= tile_dim_t'(rows);
        tile_cols    <= tile_dim_t'(cols);
        row_position <= pos_t'(rp);
        col_position <= pos_t'(cp);
        addr_ready   <= stall ? (rand_bits(2) != 0) : 1'b1;
        idle = 0;
        do begin
            @(posedge clk);
            idle++;
        end while (!start_ready && idle < TIMEOUT);
        start_valid <= 1'b0;
        if (!start_ready) begin
            $display("timeout: the request was never accepted");
            error_count++;
            aborted = 1'b1;
            return;
        end
        cycles    = 0;
        idle      = 0;
        n_seen    = 0;
        last_xfer = 0;
        seen_done = 1'b0;
        while (!seen_done && idle < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            idle++;
            if (addr_valid && addr_ready) begin
                n_seen++;
                last_xfer = cycles;
                if (exp_bank.size() == 0) begin
                    $display("extra address beyond the expected sequence, bank 0x%0h addr 0x%0h",
                             bank, addr);
                    error_count++;
                end else begin
                    idle = 0;
                    check_value("bank", bank, exp_bank.pop_front());
                    check_value("addr", addr, exp_addr.pop_front());
                end
                if (!stall)
                    check_value("addr_cycle", cycles, n_seen + 2);  // first at 3 and one per cycle
            end
            if (done) begin
                seen_done = 1'b1;
                check_value("done_cycle", cycles, (n_seen == 0) ? 3 : last_xfer + 1);
            end else begin
                check_value("start_ready", start_ready, 0);
            end
            addr_ready <= stall ? (rand_bits(2) != 0) : 1'b1;
        end
        if (!seen_done) begin
            $display("timeout: done never came after %0d addresses", n_seen);
            error_count++;
            aborted = 1'b1;
            return;
        end
        if (exp_bank.size() != 0) begin
            $display("%0d expected addresses never came out", exp_bank.size());
            error_count++;
        end
        @(posedge clk);
        check_value("start_ready", start_ready, 1);  // free again after done
        check_value("done", done, 0);
    endtask

    initial begin
        rst          = 1'b1;
        start_valid  = 1'b0;
        pad_type     = left_up;
        tile_rows    = '0;
        tile_cols    = '0;
        row_position = '0;
        col_position = '0;
        addr_ready   = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("addr_valid", addr_valid, 0);
        check_value("done", done, 0);
        check_value("start_ready", start_ready, 1);

        // every type with the output never stalled
        for (int t = 0; t <= 10 && !aborted; t++)
            run_request(t, rand_range(1, 8), rand_range(1, 8), rand_range(0, 20),
                        rand_range(0, 20), 1'b0);

        // columns around bank boundaries
        for (int k = 0; k < 12 && !aborted; k++)
            run_request(9, rand_range(1, 8), rand_range(1, 8), rand_range(0, 20),
                        3 * rand_range(1, 6) + rand_range(0, 2) - 1, k[0]);

        // random requests under back-pressure
        for (int k = 0; k < 80 && !aborted; k++)
            run_request(rand_range(0, 10), rand_range(1, 8), rand_range(1, 8),
                        rand_range(0, 20), rand_range(0, 20), 1'b1);

        $display("errors: %0d check, %0d assertion", error_count,
                 u_pad_addr_gen.u_chk.assert_errors);
        if (error_count == 0 && u_pad_addr_gen.u_chk.assert_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* project.f */
pad_pkg.sv
pad_request_decode.sv
pad_cell_walker.sv
pad_addr_result.sv
pad_addr_gen.sv
pad_addr_gen_chk.sv
tb_pad_addr_gen.sv
